/* compile.f */
source/mem_pkg.sv
source/string_pkg.sv
source/inc_by_1.sv
source/data_ram.sv
source/mem_arbiter.sv
source/string_mover.sv
source/string_filler.sv
source/string_unit_top.sv
testbench/string_unit_checker.sv
testbench/tb_string_unit.sv

/* testbench/tb_string_unit.sv */
`timescale 1ns/1ps
// Runs with 2^8 words; every check reads the word back through the host port
// cmd_word carries one op, so the two engines start in consecutive commands
module tb_string_unit;

	import string_pkg::*;
	import mem_pkg::*;

	localparam int          DEPTH_LOG2 = 8;
	localparam int          DEPTH      = 1 << DEPTH_LOG2;
	localparam logic [31:0] ADDR_MASK  = DEPTH - 1;
	localparam int          TIMEOUT    = 2000;

	logic              clk;
	logic              rst_n;
	logic              cmd_valid;
	str_cmd_t          cmd_word;
	logic              host_req;
	logic              host_we;
	logic [ADDR_W-1:0] host_addr;
	logic [DATA_W-1:0] host_wdata;
	logic              host_gnt;
	logic [DATA_W-1:0] host_rdata;
	logic              host_rvalid;
	logic              mover_busy;
	logic              mover_done;
	logic              filler_busy;
	logic              filler_done;

	logic [DATA_W-1:0] ref_mem [DEPTH];
	logic [31:0]       lcg_state;
	int                errors;
	int                assert_fails;
	int                test_num;
	int                test_fails;
	int                test_err_base;
	int                mover_done_cnt;
	int                filler_done_cnt;

	string_unit_top #(.RAM_DEPTH_LOG2(DEPTH_LOG2)) dut0 (
		.clk(clk), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd_word(cmd_word),
		.host_req(host_req), .host_we(host_we), .host_addr(host_addr),
		.host_wdata(host_wdata), .host_gnt(host_gnt), .host_rdata(host_rdata),
		.host_rvalid(host_rvalid), .mover_busy(mover_busy), .mover_done(mover_done),
		.filler_busy(filler_busy), .filler_done(filler_done)
	);

	always #2 clk = ~clk;

	// Done pulses counted so that no pulse is missed during host traffic
	always @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			mover_done_cnt  <= 0;
			filler_done_cnt <= 0;
		end
		else
		begin
			if (mover_done)
				mover_done_cnt <= mover_done_cnt + 1;
			if (filler_done)
				filler_done_cnt <= filler_done_cnt + 1;
		end
	end

	// --------------------
	// Helpers
	function automatic logic [31:0] lcg_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [31:0] rand_range(input int lo, input int hi);
		return lo + ((lcg_rand() >> 8) % (hi - lo + 1));
	endfunction

	task automatic abort_on_timeout(input string what);
		$display("Timeout: no %s within %0d cycles, stopping the run", what, TIMEOUT);
		$display("Done: errors found");
		$finish;
	endtask

	task automatic host_write(input logic [31:0] a, input logic [31:0] d);
		int n;
		n = 0;
		@(posedge clk);
		host_req   <= 1'b1;
		host_we    <= 1'b1;
		host_addr  <= a;
		host_wdata <= d;
		do
		begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT)
				abort_on_timeout("host write grant");
		end
		while (!host_gnt);
		@(posedge clk);
		host_req <= 1'b0;
		ref_mem[a & ADDR_MASK] = d;
	endtask

	task automatic host_read(input logic [31:0] a, output logic [31:0] d);
		int n;
		n = 0;
		@(posedge clk);
		host_req  <= 1'b1;
		host_we   <= 1'b0;
		host_addr <= a;
		do
		begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT)
				abort_on_timeout("host read grant");
		end
		while (!host_gnt);
		@(posedge clk);
		host_req <= 1'b0;
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT)
				abort_on_timeout("host_rvalid");
		end
		while (!host_rvalid);
		if (n != 1)
		begin
			$display("** Error at %0t ns: host_rvalid came %0d cycles after host_gnt", $time, n);
			errors++;
		end
		d = host_rdata;
	endtask

	task automatic check_word(input logic [31:0] a);
		logic [31:0] d;
		host_read(a, d);
		if (d !== ref_mem[a & ADDR_MASK])
		begin
			$display("** Error at %0t ns: word %0h reads %h, expected %h",
				$time, a & ADDR_MASK, d, ref_mem[a & ADDR_MASK]);
			errors++;
		end
	endtask

	task automatic check_range(input logic [31:0] start, input int len);
		for (int i = 0; i < len; i++)
			check_word(start + i);
	endtask

	task automatic send_cmd(input str_op_t op, input int count, input logic [31:0] first,
		input logic [31:0] dst);
		str_cmd_t c;
		c = '0;
		c.movs.op    = op;
		c.movs.count = count[CNT_W-1:0];
		c.movs.dst   = dst;
		// Fill value and source share the same field
		if (op == OP_STOS)
			c.stos.fill = first;
		else
			c.movs.src = first;
		@(posedge clk);
		cmd_valid <= 1'b1;
		cmd_word  <= c;
		@(posedge clk);
		cmd_valid <= 1'b0;
	endtask

	task automatic wait_for_done(input bit mover, input int target);
		int n;
		n = 0;
		while ((mover ? mover_done_cnt : filler_done_cnt) < target)
		begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT)
				abort_on_timeout(mover ? "mover_done" : "filler_done");
		end
	endtask

	task automatic fill_model(input logic [31:0] dst, input int count, input logic [31:0] fill);
		for (int i = 0; i < count; i++)
			ref_mem[(dst + i) & ADDR_MASK] = fill;
	endtask

	task automatic copy_model(input logic [31:0] src, input logic [31:0] dst, input int count);
		for (int i = 0; i < count; i++)
			ref_mem[(dst + i) & ADDR_MASK] = ref_mem[(src + i) & ADDR_MASK];
	endtask

	task automatic begin_test();
		test_num++;
		test_err_base = errors;
	endtask

	task automatic end_test(input string name);
		if (errors == test_err_base)
			$display("Test %0d %s: PASS", test_num, name);
		else
		begin
			$display("Test %0d %s: FAIL (%0d errors)", test_num, name, errors - test_err_base);
			test_fails++;
		end
	endtask

	// --------------------
	// Tests
	task automatic test_host();
		begin_test();
		for (int a = 0; a < DEPTH; a++)
			host_write(a, 32'h5A00_0000 ^ (a * 32'h0101_0101));
		for (int i = 0; i < 16; i++)
			host_write(lcg_rand() & ADDR_MASK, lcg_rand());
		check_range(0, DEPTH);
		end_test("host write/read");
	endtask

	task automatic test_stos(input bit wrap);
		logic [31:0] dst;
		logic [31:0] fill;
		int          count;
		int          base;
		begin_test();
		fill = lcg_rand();
		if (wrap)
		begin
			// Upper address bits are ignored by the memory
			dst   = (lcg_rand() & ~ADDR_MASK) | (DEPTH - 1 - rand_range(0, 7));
			count = rand_range(10, 20);
		end
		else
		begin
			dst   = rand_range(1, DEPTH - 42);
			count = rand_range(1, 40);
		end
		base = filler_done_cnt;
		send_cmd(OP_STOS, count, fill, dst);
		wait_for_done(1'b0, base + 1);
		fill_model(dst, count, fill);
		check_range(dst - 1, count + 2);
		end_test(wrap ? "address wrap" : "single REP STOS");
	endtask

	task automatic test_movs();
		logic [31:0] src;
		logic [31:0] dst;
		int          count;
		int          base;
		begin_test();
		src   = rand_range(8, 23);
		dst   = rand_range(128, 159);
		count = rand_range(1, 40);
		for (int i = 0; i < count; i++)
			host_write(src + i, lcg_rand());
		base = mover_done_cnt;
		send_cmd(OP_MOVS, count, src, dst);
		wait_for_done(1'b1, base + 1);
		copy_model(src, dst, count);
		check_range(src, count);
		check_range(dst - 1, count + 2);
		end_test("single REP MOVS");
	endtask

	task automatic test_zero();
		int m_base;
		int f_base;
		begin_test();
		m_base = mover_done_cnt;
		f_base = filler_done_cnt;
		send_cmd(OP_MOVS, 0, 32'h10, 32'h90);
		send_cmd(OP_STOS, 0, lcg_rand(), 32'hA0);
		for (int i = 0; i < 4; i++)
		begin
			@(negedge clk);
			if (mover_busy || filler_busy)
			begin
				$display("** Error at %0t ns: busy raised for a zero count", $time);
				errors++;
			end
		end
		wait_for_done(1'b1, m_base + 1);
		wait_for_done(1'b0, f_base + 1);
		check_range(32'h90, 4);
		check_range(32'hA0, 4);
		end_test("zero count");
	endtask

	task automatic test_concurrent();
		logic [31:0] fill;
		int          m_count;
		int          f_count;
		int          m_base;
		int          f_base;
		int          reads;
		begin_test();
		fill    = lcg_rand();
		m_count = rand_range(10, 40);
		f_count = rand_range(10, 40);
		for (int i = 0; i < m_count; i++)
			host_write(i, lcg_rand());
		m_base = mover_done_cnt;
		f_base = filler_done_cnt;
		send_cmd(OP_MOVS, m_count, 32'h00, 32'h30);
		send_cmd(OP_STOS, f_count, fill, 32'h60);
		// Host traffic to an untouched region while both engines run
		reads = 0;
		while ((mover_done_cnt < m_base + 1 || filler_done_cnt < f_base + 1) && reads < 200)
		begin
			check_word(rand_range(32'hC0, 32'hFF));
			reads++;
		end
		wait_for_done(1'b1, m_base + 1);
		wait_for_done(1'b0, f_base + 1);
		copy_model(32'h00, 32'h30, m_count);
		fill_model(32'h60, f_count, fill);
		check_range(0, DEPTH);
		end_test("concurrent engines");
	endtask

	// --------------------
	// Main sequence
	initial
	begin
		clk        = 1'b0;
		rst_n      = 1'b0;
		cmd_valid  = 1'b0;
		cmd_word   = '0;
		host_req   = 1'b0;
		host_we    = 1'b0;
		host_addr  = '0;
		host_wdata = '0;
		lcg_state  = 32'd96;
		errors     = 0;
		test_num   = 0;
		test_fails = 0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		test_host();
		test_stos(1'b0);
		test_movs();
		test_zero();
		test_concurrent();
		test_stos(1'b1);

		// Bound assertions keep their own failure counts
		assert_fails = dut0.u_arbiter.u_arb_check.fail_count
			+ dut0.u_mover.u_mover_check.fail_count;
		$display("Summary: %0d tests, %0d failed, %0d errors, %0d assertion failures",
			test_num, test_fails, errors, assert_fails);
		if (errors == 0 && assert_fails == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* testbench/string_unit_checker.sv */
`timescale 1ns/1ps
// Request/grant and busy/done checks, shared by the arbiter and the mover
// The arbiter has no busy or done, so its bind ties them low and clears HAS_DONE
module string_unit_checker #(
	parameter int N        = 1,
	parameter bit HAS_DONE = 1'b1
) (
	input logic         clk,
	input logic         rst_n,
	input logic [N-1:0] req,
	input logic [N-1:0] gnt,
	input logic         busy,
	input logic         done
);

	genvar i;

	// Running count of assertion failures, read by the testbench at the end
	int fail_count = 0;

	// Only a grant vector can carry more than one grant
	generate
		if (N > 1)
		begin : gen_onehot
			a_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(gnt))
				else
				begin
					fail_count++;
					$error("more than one grant in the same cycle");
				end
		end
	endgenerate

	a_gnt_has_req: assert property (@(posedge clk) disable iff (!rst_n) (gnt & ~req) == '0)
		else
		begin
			fail_count++;
			$error("grant given without a request");
		end

	// A waiting requester keeps asking
	generate
		for (i = 0; i < N; i = i + 1)
		begin : gen_hold
			a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
				(req[i] && !gnt[i]) |=> req[i])
				else
				begin
					fail_count++;
					$error("request %0d dropped before its grant", i);
				end
		end
	endgenerate

	generate
		if (HAS_DONE)
		begin : gen_done
			a_done_rise: assert property (@(posedge clk) disable iff (!rst_n)
				!(done && $rose(busy)))
				else
				begin
					fail_count++;
					$error("done pulsed while busy was rising");
				end
		end
	endgenerate

endmodule

bind mem_arbiter string_unit_checker #(.N(mem_pkg::NUM_REQ), .HAS_DONE(1'b0)) u_arb_check (
	.clk(clk), .rst_n(rst_n), .req(req), .gnt(gnt), .busy(1'b0), .done(1'b0)
);

bind string_mover string_unit_checker #(.N(1)) u_mover_check (
	.clk(clk), .rst_n(rst_n), .req(req), .gnt(gnt), .busy(busy), .done(done)
);

/* source/string_unit_top.sv */
`timescale 1ns/1ps
// Commands for a busy engine and NOPs are dropped
// host_rdata is valid with host_rvalid, one cycle after a read grant
module string_unit_top #(
	parameter int RAM_DEPTH_LOG2 = 8
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       cmd_valid,
	input  string_pkg::str_cmd_t       cmd_word,
	input  logic                       host_req,
	input  logic                       host_we,
	input  logic [mem_pkg::ADDR_W-1:0] host_addr,
	input  logic [mem_pkg::DATA_W-1:0] host_wdata,
	output logic                       host_gnt,
	output logic [mem_pkg::DATA_W-1:0] host_rdata,
	output logic                       host_rvalid,
	output logic                       mover_busy,
	output logic                       mover_done,
	output logic                       filler_busy,
	output logic                       filler_done
);

	import string_pkg::*;
	import mem_pkg::*;

	logic                            mover_start;
	logic                            filler_start;
	logic                            mover_req;
	logic                            mover_we;
	logic [ADDR_W-1:0]               mover_addr;
	logic [DATA_W-1:0]               mover_wdata;
	logic                            filler_req;
	logic                            filler_we;
	logic [ADDR_W-1:0]               filler_addr;
	logic [DATA_W-1:0]               filler_wdata;
	logic [NUM_REQ-1:0]              req;
	logic [NUM_REQ-1:0]              we;
	logic [NUM_REQ-1:0][ADDR_W-1:0]  addr;
	logic [NUM_REQ-1:0][DATA_W-1:0]  wdata;
	logic [NUM_REQ-1:0]              gnt;
	logic [NUM_REQ-1:0]              rvalid_id;
	logic                            ram_en;
	logic                            ram_we;
	logic [RAM_DEPTH_LOG2-1:0]       ram_addr;
	logic [DATA_W-1:0]               ram_wdata;
	logic [DATA_W-1:0]               ram_rdata;

	// --------------------
	// Command decode
	assign mover_start  = cmd_valid && (cmd_word.movs.op == OP_MOVS) && !mover_busy;
	assign filler_start = cmd_valid && (cmd_word.stos.op == OP_STOS) && !filler_busy;

	// Requester slots
	assign req   = {filler_req, mover_req, host_req};
	assign we    = {filler_we, mover_we, host_we};
	assign addr  = {filler_addr, mover_addr, host_addr};
	assign wdata = {filler_wdata, mover_wdata, host_wdata};

	assign host_gnt    = gnt[REQ_HOST];
	assign host_rvalid = rvalid_id[REQ_HOST];
	assign host_rdata  = ram_rdata;

	// --------------------
	// Engines, arbiter and memory
	string_mover u_mover (
		.clk(clk), .rst_n(rst_n), .start(mover_start), .cmd(cmd_word),
		.gnt(gnt[REQ_MOVER]), .rvalid(rvalid_id[REQ_MOVER]), .rdata(ram_rdata),
		.req(mover_req), .we(mover_we), .addr(mover_addr), .wdata(mover_wdata),
		.busy(mover_busy), .done(mover_done)
	);

	string_filler u_filler (
		.clk(clk), .rst_n(rst_n), .start(filler_start), .cmd(cmd_word),
		.gnt(gnt[REQ_FILLER]), .req(filler_req), .we(filler_we), .addr(filler_addr),
		.wdata(filler_wdata), .busy(filler_busy), .done(filler_done)
	);

	mem_arbiter #(.RAM_DEPTH_LOG2(RAM_DEPTH_LOG2)) u_arbiter (
		.clk(clk), .rst_n(rst_n), .req(req), .we(we), .addr(addr), .wdata(wdata),
		.gnt(gnt), .ram_en(ram_en), .ram_we(ram_we), .ram_addr(ram_addr),
		.ram_wdata(ram_wdata), .rvalid_id(rvalid_id)
	);

	data_ram #(.RAM_DEPTH_LOG2(RAM_DEPTH_LOG2)) u_ram (
		.clk(clk), .en(ram_en), .we(ram_we), .addr(ram_addr),
		.wdata(ram_wdata), .rdata(ram_rdata)
	);

endmodule

/* source/string_filler.sv */
`timescale 1ns/1ps
// REP STOS engine, writes the fill word to ascending destination words
// Writes go back to back whenever the arbiter grants
module string_filler (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       start,
	input  string_pkg::str_cmd_t       cmd,
	input  logic                       gnt,
	output logic                       req,
	output logic                       we,
	output logic [mem_pkg::ADDR_W-1:0] addr,
	output logic [mem_pkg::DATA_W-1:0] wdata,
	output logic                       busy,
	output logic                       done
);

	import string_pkg::*;
	import mem_pkg::*;

	logic              writing;
	logic [ADDR_W-1:0] dst_q;
	logic [ADDR_W-1:0] dst_inc;
	logic [DATA_W-1:0] fill_q;
	logic [CNT_W-1:0]  cnt_q;
	logic [CNT_W-1:0]  cnt_next;
	logic [ADDR_W-1:0] cnt_cpl;
	logic [ADDR_W-1:0] cnt_cpl_inc;

	// --------------------
	// Steppers
	inc_by_1 u_dst_inc (.a(dst_q), .sum(dst_inc), .carry_out());

	assign cnt_cpl = {{(ADDR_W-CNT_W){1'b0}}, ~cnt_q};
	inc_by_1 u_cnt_inc (.a(cnt_cpl), .sum(cnt_cpl_inc), .carry_out());
	assign cnt_next = ~cnt_cpl_inc[CNT_W-1:0];

	// Always a write request while active
	assign req   = writing;
	assign we    = writing;
	assign addr  = dst_q;
	assign wdata = fill_q;

	// --------------------
	// Idle / write states
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			writing <= 1'b0;
			cnt_q   <= '0;
			busy    <= 1'b0;
			done    <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (!writing && start)
			begin
				cnt_q <= cmd.stos.count;
				if (cmd.stos.count == '0)
					done <= 1'b1;
				else
				begin
					busy    <= 1'b1;
					writing <= 1'b1;
				end
			end
			else if (writing && gnt)
			begin
				cnt_q <= cnt_next;
				if (cnt_next == '0)
				begin
					busy    <= 1'b0;
					done    <= 1'b1;
					writing <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!writing && start)
		begin
			dst_q  <= cmd.stos.dst;
			fill_q <= cmd.stos.fill;
		end
		else if (writing && gnt)
			dst_q <= dst_inc;
	end

endmodule

/* source/string_mover.sv */
`timescale 1ns/1ps
// REP MOVS engine, one word per element, ascending addresses
// start is taken only while idle; a zero count gives done without memory traffic
module string_mover (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       start,
	input  string_pkg::str_cmd_t       cmd,
	input  logic                       gnt,
	input  logic                       rvalid,
	input  logic [mem_pkg::DATA_W-1:0] rdata,
	output logic                       req,
	output logic                       we,
	output logic [mem_pkg::ADDR_W-1:0] addr,
	output logic [mem_pkg::DATA_W-1:0] wdata,
	output logic                       busy,
	output logic                       done
);

	import string_pkg::*;
	import mem_pkg::*;

	localparam logic [2:0] S_IDLE   = 3'd0;
	localparam logic [2:0] S_RD_REQ = 3'd1;
	localparam logic [2:0] S_WAIT   = 3'd2;
	localparam logic [2:0] S_WR_REQ = 3'd3;
	localparam logic [2:0] S_STEP   = 3'd4;

	logic [2:0]        state;
	logic [ADDR_W-1:0] src_q;
	logic [ADDR_W-1:0] dst_q;
	logic [ADDR_W-1:0] src_inc;
	logic [ADDR_W-1:0] dst_inc;
	logic [CNT_W-1:0]  cnt_q;
	logic [CNT_W-1:0]  cnt_next;
	logic [ADDR_W-1:0] cnt_cpl;
	logic [ADDR_W-1:0] cnt_cpl_inc;
	logic [DATA_W-1:0] data_q;

	// --------------------
	// Steppers
	inc_by_1 u_src_inc (.a(src_q), .sum(src_inc), .carry_out());
	inc_by_1 u_dst_inc (.a(dst_q), .sum(dst_inc), .carry_out());

	// count - 1 as the complement of (complement + 1)
	assign cnt_cpl = {{(ADDR_W-CNT_W){1'b0}}, ~cnt_q};
	inc_by_1 u_cnt_inc (.a(cnt_cpl), .sum(cnt_cpl_inc), .carry_out());
	assign cnt_next = ~cnt_cpl_inc[CNT_W-1:0];

	// --------------------
	// Memory request
	assign req   = (state == S_RD_REQ) || (state == S_WR_REQ);
	assign we    = (state == S_WR_REQ);
	assign addr  = (state == S_WR_REQ) ? dst_q : src_q;
	assign wdata = data_q;

	// Control FSM
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= S_IDLE;
			cnt_q <= '0;
			busy  <= 1'b0;
			done  <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				S_IDLE:
				begin
					if (start)
					begin
						cnt_q <= cmd.movs.count;
						if (cmd.movs.count == '0)
							done <= 1'b1;
						else
						begin
							busy  <= 1'b1;
							state <= S_RD_REQ;
						end
					end
				end
				S_RD_REQ:
					if (gnt)
						state <= S_WAIT;
				S_WAIT:
					if (rvalid)
						state <= S_WR_REQ;
				S_WR_REQ:
				begin
					// Last element ends right at its write grant
					if (gnt && cnt_next == '0)
					begin
						busy  <= 1'b0;
						done  <= 1'b1;
						state <= S_IDLE;
					end
					else if (gnt)
						state <= S_STEP;
				end
				S_STEP:
				begin
					cnt_q <= cnt_next;
					state <= S_RD_REQ;
				end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// Addresses and the word in flight
	always_ff @(posedge clk)
	begin
		if (state == S_IDLE && start)
		begin
			src_q <= cmd.movs.src;
			dst_q <= cmd.movs.dst;
		end
		else if (state == S_STEP)
		begin
			src_q <= src_inc;
			dst_q <= dst_inc;
		end
		if (state == S_WAIT && rvalid)
			data_q <= rdata;
	end

endmodule

/* source/mem_arbiter.sv */
`timescale 1ns/1ps
// Host has strict priority, mover and filler alternate when both request
// Grant is combinational; rvalid_id marks read data one cycle after the grant
module mem_arbiter #(
	parameter int RAM_DEPTH_LOG2 = 8
) (
	input  logic                                              clk,
	input  logic                                              rst_n,
	input  logic [mem_pkg::NUM_REQ-1:0]                       req,
	input  logic [mem_pkg::NUM_REQ-1:0]                       we,
	input  logic [mem_pkg::NUM_REQ-1:0][mem_pkg::ADDR_W-1:0]  addr,
	input  logic [mem_pkg::NUM_REQ-1:0][mem_pkg::DATA_W-1:0]  wdata,
	output logic [mem_pkg::NUM_REQ-1:0]                       gnt,
	output logic                                              ram_en,
	output logic                                              ram_we,
	output logic [RAM_DEPTH_LOG2-1:0]                         ram_addr,
	output logic [mem_pkg::DATA_W-1:0]                        ram_wdata,
	output logic [mem_pkg::NUM_REQ-1:0]                       rvalid_id
);

	import mem_pkg::*;

	// Set when the mover won the last engine grant
	logic last_mover;

	// --------------------
	// Grant
	always_comb
	begin
		gnt = '0;
		if (req[REQ_HOST])
			gnt[REQ_HOST] = 1'b1;
		else if (req[REQ_MOVER] && req[REQ_FILLER])
		begin
			if (last_mover)
				gnt[REQ_FILLER] = 1'b1;
			else
				gnt[REQ_MOVER] = 1'b1;
		end
		else if (req[REQ_MOVER])
			gnt[REQ_MOVER] = 1'b1;
		else if (req[REQ_FILLER])
			gnt[REQ_FILLER] = 1'b1;
	end

	// --------------------
	// Winner to the RAM
	assign ram_en = |gnt;

	always_comb
	begin
		ram_we    = 1'b0;
		ram_addr  = '0;
		ram_wdata = '0;
		for (int i = 0; i < NUM_REQ; i++)
		begin
			if (gnt[i])
			begin
				ram_we    = we[i];
				ram_addr  = addr[i][RAM_DEPTH_LOG2-1:0];
				ram_wdata = wdata[i];
			end
		end
	end

	// Round-robin state and read return tag
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			last_mover <= 1'b0;
			rvalid_id  <= '0;
		end
		else
		begin
			if (gnt[REQ_MOVER])
				last_mover <= 1'b1;
			else if (gnt[REQ_FILLER])
				last_mover <= 1'b0;
			rvalid_id <= gnt & ~we;
		end
	end

endmodule

/* source/data_ram.sv */
`timescale 1ns/1ps
// Single-port word RAM, no reset on contents
// Read data appears the cycle after an enabled read and holds until the next read
module data_ram #(
	parameter int RAM_DEPTH_LOG2 = 8
) (
	input  logic                       clk,
	input  logic                       en,
	input  logic                       we,
	input  logic [RAM_DEPTH_LOG2-1:0]  addr,
	input  logic [mem_pkg::DATA_W-1:0] wdata,
	output logic [mem_pkg::DATA_W-1:0] rdata
);

	import mem_pkg::*;

	localparam int DEPTH = 1 << RAM_DEPTH_LOG2;

	logic [DATA_W-1:0] mem [DEPTH];

	// Write or registered read, never both
	always_ff @(posedge clk)
	begin
		if (en)
		begin
			if (we)
				mem[addr] <= wdata;
			else
				rdata <= mem[addr];
		end
	end

endmodule

/* source/inc_by_1.sv */
`timescale 1ns/1ps
// Fixed 32-bit increment, purely combinational
// sum wraps to zero when a is all ones, carry_out flags that case
module inc_by_1 (
	input  logic [mem_pkg::ADDR_W-1:0] a,
	output logic [mem_pkg::ADDR_W-1:0] sum,
	output logic                       carry_out
);

	// AND of each 4-bit group
	logic [7:0]  grp_all;
	// AND of the lower groups inside the same 16-bit half
	logic [7:0]  grp_pre;
	// AND of the lower bits inside the same group
	logic [31:0] in_grp;
	logic        lo_half_all;
	logic        hi_half_all;
	// Carry into each bit
	logic [31:0] carry_in;

	genvar g, b;

	// --------------------
	// Group level
	generate
		for (g = 0; g < 8; g = g + 1)
		begin : gen_group
			assign grp_all[g] = &a[4*g +: 4];
			if (g % 4 == 0)
			begin : gen_pre_first
				assign grp_pre[g] = 1'b1;
			end
			else
			begin : gen_pre_rest
				assign grp_pre[g] = &grp_all[g-1 -: (g % 4)];
			end
		end
	endgenerate

	assign lo_half_all = &grp_all[3:0];
	assign hi_half_all = &grp_all[7:4];

	// --------------------
	// Bit level
	generate
		for (b = 0; b < 32; b = b + 1)
		begin : gen_bit
			if (b % 4 == 0)
			begin : gen_in_first
				assign in_grp[b] = 1'b1;
			end
			else
			begin : gen_in_rest
				assign in_grp[b] = &a[b-1 -: (b % 4)];
			end
			// Upper half also needs the whole lower half set
			if (b < 16)
			begin : gen_lo
				assign carry_in[b] = in_grp[b] & grp_pre[b/4];
			end
			else
			begin : gen_hi
				assign carry_in[b] = in_grp[b] & grp_pre[b/4] & lo_half_all;
			end
		end
	endgenerate

	assign sum       = a ^ carry_in;
	assign carry_out = lo_half_all & hi_half_all;

endmodule

/* source/string_pkg.sv */
// String command encodings. Every element is one 32-bit word, addresses ascend
// Refers to mem_pkg by scoped names, so mem_pkg compiles first
package string_pkg;

	// Element count width
	localparam int CNT_W = 14;

	// --------------------
	// Opcodes
	typedef enum logic [1:0] {
		OP_NOP  = 2'd0,
		OP_MOVS = 2'd1,
		OP_STOS = 2'd2
	} str_op_t;

	// REP MOVS view of the command word
	typedef struct packed {
		str_op_t                   op;
		logic [CNT_W-1:0]          count;
		logic [mem_pkg::ADDR_W-1:0] src;
		logic [mem_pkg::ADDR_W-1:0] dst;
	} movs_view_t;

	// REP STOS view, fill value sits where MOVS keeps its source
	typedef struct packed {
		str_op_t                   op;
		logic [CNT_W-1:0]          count;
		logic [mem_pkg::DATA_W-1:0] fill;
		logic [mem_pkg::ADDR_W-1:0] dst;
	} stos_view_t;

	// --------------------
	// 80-bit command word
	// op, count and dst line up in both views
	typedef union packed {
		movs_view_t movs;
		stos_view_t stos;
	} str_cmd_t;

endpackage

/* source/mem_pkg.sv */
// Memory widths and arbiter requester slots
// Addresses are word addresses, the RAM decodes only the low bits
package mem_pkg;

	// --------------------
	// Widths
	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;

	// --------------------
	// Arbiter requesters
	localparam int NUM_REQ = 3;

	// Host always wins
	localparam int REQ_HOST = 0;

	// Engines share the rest round-robin
	localparam int REQ_MOVER  = 1;
	localparam int REQ_FILLER = 2;

endpackage
